// File: include/huff_defines.svh
`ifndef HUFF_DEFINES_SVH
`define HUFF_DEFINES_SVH

// coefficient block
`define HUFF_COEF_W   8
`define HUFF_NUM_COEF 4

// category 0..8
`define HUFF_CAT_W    4

// code table entry
`define HUFF_CODE_W   16
`define HUFF_LEN_W    5

// zero run within one block
`define HUFF_RUN_W    2

// code table address and component select
`define HUFF_TBL_AW   8
`define HUFF_COMP_W   2

`endif

// File: hdl/huff_pkg.sv
`include "huff_defines.svh"

package huff_pkg;

    // table section, top two address bits
    typedef enum logic [1:0] {
        TBL_DC  = 2'd0,
        TBL_AC  = 2'd1,
        TBL_EOB = 2'd2
    } tbl_kind_t;

    typedef struct packed {
        tbl_kind_t                kind;
        logic [1:0]               pad;
        logic [`HUFF_CAT_W-1:0]   cat;
    } dc_addr_t;

    typedef struct packed {
        tbl_kind_t                kind;
        logic [`HUFF_RUN_W-1:0]   run;
        logic [`HUFF_CAT_W-1:0]   size;
    } ac_addr_t;

    // one address word, two decodings
    typedef union packed {
        dc_addr_t dc;
        ac_addr_t ac;
    } tbl_addr_u;

    typedef logic [`HUFF_CODE_W-1:0] huff_code_t;
    typedef logic [`HUFF_LEN_W-1:0]  huff_len_t;

endpackage

// File: hdl/huff_wr_if.sv
`timescale 1ns/1ps

// code writes from the FSM into the bit packer
interface huff_wr_if import huff_pkg::*; ();

    logic       w_en;
    huff_code_t code;
    huff_len_t  len;
    logic       flush;
    logic       busy;

    modport src (
        output w_en, code, len, flush,
        input  busy
    );

    modport sink (
        input  w_en, code, len, flush,
        output busy
    );

endinterface

// File: hdl/huff_code_table.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module huff_code_table import huff_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_we,
    input  tbl_addr_u  i_waddr,
    input  huff_code_t i_wcode,
    input  huff_len_t  i_wlen,
    input  tbl_addr_u  i_raddr,
    output huff_code_t o_code,
    output huff_len_t  o_len
);

    localparam int DEPTH = 1 << `HUFF_TBL_AW;

    // dc, ac and eob sections share one store
    huff_code_t code_mem [DEPTH];
    huff_len_t  len_mem  [DEPTH];

    // writes are ignored while in reset
    always_ff @(posedge clk) begin
        if (n_rst && i_we) begin
            code_mem[i_waddr] <= i_wcode;
            len_mem[i_waddr]  <= i_wlen;
        end
    end

    always_comb begin
        o_code = code_mem[i_raddr];
        o_len  = len_mem[i_raddr];
    end

endmodule

// File: hdl/coef_coder.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module coef_coder import huff_pkg::*; (
    input  logic                                         clk,
    input  logic                                         n_rst,
    input  logic                                         i_wait,
    input  logic [`HUFF_NUM_COEF-1:0][`HUFF_COEF_W-1:0]  i_data,
    input  logic [`HUFF_COMP_W-1:0]                      i_comp,
    input  logic [$clog2(`HUFF_NUM_COEF)-1:0]            i_index,
    input  logic                                         i_dc_done,
    output logic [`HUFF_CAT_W-1:0]                       o_cat,
    output huff_code_t                                   o_amp
);

    // dc difference needs one extra bit
    localparam int DIFF_W = `HUFF_COEF_W + 1;

    logic signed [`HUFF_COEF_W-1:0] pred [3];
    logic signed [`HUFF_COEF_W-1:0] pred_sel;
    logic signed [`HUFF_COEF_W-1:0] coef_sel;
    logic signed [DIFF_W-1:0]       value;
    logic [DIFF_W-1:0]              mag;
    logic [DIFF_W-1:0]              ones_val;
    huff_code_t                     amp_mask;

    // ----------------------------------------
    // dc predictors, one per component
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            pred[0] <= '0;
            pred[1] <= '0;
            pred[2] <= '0;
        end else if (!i_wait && i_dc_done && (i_comp < `HUFF_COMP_W'(3))) begin
            pred[i_comp] <= i_data[0];
        end
    end

    always_comb begin
        case (i_comp)
            `HUFF_COMP_W'(0): pred_sel = pred[0];
            `HUFF_COMP_W'(1): pred_sel = pred[1];
            `HUFF_COMP_W'(2): pred_sel = pred[2];
            default:          pred_sel = '0;
        endcase
    end

    // ----------------------------------------
    // value, category and amplitude bits
    // ----------------------------------------
    always_comb begin
        coef_sel = i_data[i_index];
        if (i_index == '0) begin
            value = DIFF_W'(coef_sel) - DIFF_W'(pred_sel);
        end else begin
            value = DIFF_W'(coef_sel);
        end

        // magnitude and one's complement form
        if (value[DIFF_W-1]) begin
            mag      = -value;
            ones_val = value - DIFF_W'(1);
        end else begin
            mag      = value;
            ones_val = value;
        end
    end

    // category is the bit count of the magnitude
    always_comb begin
        o_cat = '0;
        for (int b = 0; b < DIFF_W; b++) begin
            if (mag[b]) begin
                o_cat = `HUFF_CAT_W'(b + 1);
            end
        end
    end

    always_comb begin
        amp_mask = (huff_code_t'(1) << o_cat) - huff_code_t'(1);
        o_amp    = huff_code_t'(ones_val) & amp_mask;
    end

endmodule

// File: hdl/run_counter.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module run_counter (
    input  logic                                         clk,
    input  logic                                         n_rst,
    input  logic                                         i_wait,
    input  logic                                         i_start,
    input  logic                                         i_advance,
    input  logic [`HUFF_NUM_COEF-1:0][`HUFF_COEF_W-1:0]  i_data,
    output logic [$clog2(`HUFF_NUM_COEF)-1:0]            o_index,
    output logic [`HUFF_RUN_W-1:0]                       o_run,
    output logic [$clog2(`HUFF_NUM_COEF)-1:0]            o_last_nz,
    output logic                                         o_at_last
);

    localparam int IDX_W = $clog2(`HUFF_NUM_COEF);

    logic [IDX_W-1:0] nz_pos;

    // last nonzero ac position, 0 when all ac are zero
    always_comb begin
        nz_pos = '0;
        for (int i = 1; i < `HUFF_NUM_COEF; i++) begin
            if (i_data[i] != '0) begin
                nz_pos = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_index   <= '0;
            o_run     <= '0;
            o_last_nz <= '0;
        end else if (!i_wait) begin
            if (i_start) begin
                o_index   <= '0;
                o_run     <= '0;
                o_last_nz <= nz_pos;
            end else if (i_advance) begin
                o_index <= o_index + IDX_W'(1);
                // dc or a nonzero coefficient ends the run
                if ((o_index != '0) && (i_data[o_index] == '0)) begin
                    o_run <= o_run + `HUFF_RUN_W'(1);
                end else begin
                    o_run <= '0;
                end
            end
        end
    end

    assign o_at_last = (o_index == IDX_W'(`HUFF_NUM_COEF - 1));

endmodule

// File: hdl/encode_fsm.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module encode_fsm import huff_pkg::*; (
    input  logic                               clk,
    input  logic                               n_rst,
    input  logic                               i_wait,
    input  logic                               i_start,
    input  logic [`HUFF_CAT_W-1:0]             i_cat,
    input  huff_code_t                         i_amp,
    input  logic [`HUFF_RUN_W-1:0]             i_run,
    input  logic [$clog2(`HUFF_NUM_COEF)-1:0]  i_last_nz,
    input  logic                               i_at_last,
    input  logic [$clog2(`HUFF_NUM_COEF)-1:0]  i_index,
    input  huff_code_t                         i_code,
    input  huff_len_t                          i_len,
    output tbl_addr_u                          o_raddr,
    output logic                               o_advance,
    output logic                               o_dc_done,
    output logic                               o_start_scan,
    output logic                               o_done,
    huff_wr_if.src                             wr
);

    typedef enum logic [3:0] {
        IDLE, DC_CODE, DC_AMP, AC_STEP, AC_CODE, AC_AMP, EOB, FLUSH, DRAIN
    } state_t;

    state_t    state;
    state_t    next_state;
    logic      go;
    huff_len_t amp_len;

    // a write goes out only when not stalled and the packer is free
    assign go      = !i_wait && !wr.busy;
    assign amp_len = {{(`HUFF_LEN_W - `HUFF_CAT_W){1'b0}}, i_cat};

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= IDLE;
        end else if (!i_wait) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        o_raddr      = '0;
        o_advance    = 1'b0;
        o_dc_done    = 1'b0;
        o_start_scan = 1'b0;
        o_done       = 1'b0;
        wr.w_en      = 1'b0;
        wr.code      = '0;
        wr.len       = '0;
        wr.flush     = 1'b0;
        case (state)
            IDLE: begin
                if (!i_wait && i_start) begin
                    o_start_scan = 1'b1;
                    next_state   = DC_CODE;
                end
            end
            DC_CODE: begin
                o_raddr.dc.kind = TBL_DC;
                o_raddr.dc.cat  = i_cat;
                wr.code         = i_code;
                wr.len          = i_len;
                if (go) begin
                    wr.w_en = 1'b1;
                    // no amplitude bits for a zero difference
                    if (i_cat == '0) begin
                        o_dc_done  = 1'b1;
                        o_advance  = 1'b1;
                        next_state = AC_STEP;
                    end else begin
                        next_state = DC_AMP;
                    end
                end
            end
            DC_AMP: begin
                wr.code = i_amp;
                wr.len  = amp_len;
                if (go) begin
                    wr.w_en    = 1'b1;
                    o_dc_done  = 1'b1;
                    o_advance  = 1'b1;
                    next_state = AC_STEP;
                end
            end
            AC_STEP: begin
                // past the last nonzero, only EOB remains
                if (i_index > i_last_nz) begin
                    next_state = EOB;
                end else if (i_cat == '0) begin
                    o_advance = !i_wait;
                end else begin
                    next_state = AC_CODE;
                end
            end
            AC_CODE: begin
                o_raddr.ac.kind = TBL_AC;
                o_raddr.ac.run  = i_run;
                o_raddr.ac.size = i_cat;
                wr.code         = i_code;
                wr.len          = i_len;
                if (go) begin
                    wr.w_en    = 1'b1;
                    next_state = AC_AMP;
                end
            end
            AC_AMP: begin
                wr.code = i_amp;
                wr.len  = amp_len;
                if (go) begin
                    wr.w_en = 1'b1;
                    if (i_at_last) begin
                        next_state = FLUSH;
                    end else begin
                        o_advance  = 1'b1;
                        next_state = AC_STEP;
                    end
                end
            end
            EOB: begin
                o_raddr.ac.kind = TBL_EOB;
                wr.code         = i_code;
                wr.len          = i_len;
                if (go) begin
                    wr.w_en    = 1'b1;
                    next_state = FLUSH;
                end
            end
            FLUSH: begin
                if (go) begin
                    wr.flush   = 1'b1;
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                // busy falls once the padded byte is out
                if (go) begin
                    o_done     = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: hdl/bit_packer.sv
`timescale 1ns/1ps

module bit_packer import huff_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_wait,
    huff_wr_if.sink    wr,
    output logic       o_valid,
    output logic [7:0] o_data
);

    localparam int ACC_W = 24;
    localparam int CNT_W = $clog2(ACC_W + 1);

    // held bits are left aligned in acc
    logic [ACC_W-1:0] acc;
    logic [CNT_W-1:0] count;
    logic [ACC_W-1:0] keep_mask;
    logic [ACC_W-1:0] placed;
    logic [CNT_W-1:0] shamt;
    huff_code_t       code_masked;
    logic             emit;

    always_comb begin
        emit        = (count >= CNT_W'(8));
        code_masked = wr.code & ((huff_code_t'(1) << wr.len) - huff_code_t'(1));
        shamt       = CNT_W'(ACC_W) - count - CNT_W'(wr.len);
        placed      = ACC_W'(code_masked) << shamt;
        keep_mask   = ~({ACC_W{1'b1}} >> count);
    end

    // ----------------------------------------
    // accumulator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            count <= '0;
        end else if (!i_wait) begin
            if (emit) begin
                acc   <= acc << 8;
                count <= count - CNT_W'(8);
            end else if (wr.w_en) begin
                acc   <= (acc & keep_mask) | placed;
                count <= count + CNT_W'(wr.len);
            end else if (wr.flush && (count != '0)) begin
                // pad the partial byte with ones
                acc[ACC_W-1 -: 8] <= acc[ACC_W-1 -: 8] | (8'hff >> count);
                count             <= CNT_W'(8);
            end
        end
    end

    // full byte on top, no writes until it drains
    assign wr.busy = emit;
    assign o_valid = emit && !i_wait;
    assign o_data  = acc[ACC_W-1 -: 8];

endmodule

// File: hdl/huff_enc_top.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module huff_enc_top import huff_pkg::*; (
    input  logic                                         clk,
    input  logic                                         n_rst,
    input  logic                                         i_tbl_we,
    input  logic [`HUFF_TBL_AW-1:0]                      i_tbl_addr,
    input  logic [`HUFF_CODE_W-1:0]                      i_tbl_code,
    input  logic [`HUFF_LEN_W-1:0]                       i_tbl_len,
    input  logic                                         i_start,
    input  logic                                         i_wait,
    input  logic [`HUFF_COMP_W-1:0]                      i_comp,
    input  logic [`HUFF_NUM_COEF-1:0][`HUFF_COEF_W-1:0]  i_data,
    output logic                                         o_valid,
    output logic [7:0]                                   o_data,
    output logic                                         o_done
);

    localparam int IDX_W = $clog2(`HUFF_NUM_COEF);

    tbl_addr_u               raddr;
    huff_code_t              code;
    huff_len_t               len;
    logic [`HUFF_CAT_W-1:0]  cat;
    huff_code_t              amp;
    logic [IDX_W-1:0]        index;
    logic [`HUFF_RUN_W-1:0]  run;
    logic [IDX_W-1:0]        last_nz;
    logic                    at_last;
    logic                    advance;
    logic                    dc_done;
    logic                    start_scan;

    huff_wr_if wr_bus ();

    huff_code_table u_table (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_we    (i_tbl_we),
        .i_waddr (i_tbl_addr),
        .i_wcode (i_tbl_code),
        .i_wlen  (i_tbl_len),
        .i_raddr (raddr),
        .o_code  (code),
        .o_len   (len)
    );

    coef_coder u_coef (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_wait    (i_wait),
        .i_data    (i_data),
        .i_comp    (i_comp),
        .i_index   (index),
        .i_dc_done (dc_done),
        .o_cat     (cat),
        .o_amp     (amp)
    );

    run_counter u_run (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_wait    (i_wait),
        .i_start   (start_scan),
        .i_advance (advance),
        .i_data    (i_data),
        .o_index   (index),
        .o_run     (run),
        .o_last_nz (last_nz),
        .o_at_last (at_last)
    );

    encode_fsm u_fsm (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_wait       (i_wait),
        .i_start      (i_start),
        .i_cat        (cat),
        .i_amp        (amp),
        .i_run        (run),
        .i_last_nz    (last_nz),
        .i_at_last    (at_last),
        .i_index      (index),
        .i_code       (code),
        .i_len        (len),
        .o_raddr      (raddr),
        .o_advance    (advance),
        .o_dc_done    (dc_done),
        .o_start_scan (start_scan),
        .o_done       (o_done),
        .wr           (wr_bus.src)
    );

    bit_packer u_packer (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_wait  (i_wait),
        .wr      (wr_bus.sink),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

endmodule

// File: test/tb_huff_enc.sv
`timescale 1ns/1ps

`include "huff_defines.svh"

module tb_huff_enc;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;
    localparam int MAX_CYCLES = 500;
    localparam int NUM_RANDOM = 12;

    logic                                         clk;
    logic                                         n_rst;
    logic                                         i_tbl_we;
    logic [`HUFF_TBL_AW-1:0]                      i_tbl_addr;
    logic [`HUFF_CODE_W-1:0]                      i_tbl_code;
    logic [`HUFF_LEN_W-1:0]                       i_tbl_len;
    logic                                         i_start;
    logic                                         i_wait;
    logic [`HUFF_COMP_W-1:0]                      i_comp;
    logic [`HUFF_NUM_COEF-1:0][`HUFF_COEF_W-1:0]  i_data;
    logic                                         o_valid;
    logic [7:0]                                   o_data;
    logic                                         o_done;

    // own copy of the code table and dc predictors
    logic [`HUFF_CODE_W-1:0] ref_code [256];
    logic [`HUFF_LEN_W-1:0]  ref_len  [256];
    int                      ref_pred [3];

    // stimulus table with one entry per block
    int                                           row_comp [$];
    logic [`HUFF_NUM_COEF-1:0][`HUFF_COEF_W-1:0]  row_data [$];
    bit                                           row_stall [$];
    int                                           row_variant [$];

    bit         bit_q [$];
    logic [7:0] exp_q [$];

    integer seed;
    int     stall_left;
    int     pass_count;
    int     fail_count;
    int     loaded;
    bit     aborted;

    huff_enc_top DUT (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_tbl_we   (i_tbl_we),
        .i_tbl_addr (i_tbl_addr),
        .i_tbl_code (i_tbl_code),
        .i_tbl_len  (i_tbl_len),
        .i_start    (i_start),
        .i_wait     (i_wait),
        .i_comp     (i_comp),
        .i_data     (i_data),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .o_done     (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // two variants of the code table
    // ----------------------------------------
    function automatic void table_entry(input int variant, input logic [7:0] addr,
                                        output logic [15:0] code, output logic [4:0] len);
        logic [1:0] kind;
        logic [1:0] run;
        logic [3:0] size;
        int         k;
        kind = addr[7:6];
        run  = addr[5:4];
        size = addr[3:0];
        k    = int'(run) * 8 + int'(size) - 1;
        // slots never read
        code = {addr, ~addr};
        len  = 5'd0;
        if (kind == 2'd0 && run == 2'd0 && size <= 4'd8) begin
            code = (variant == 0) ? 16'((1 << (int'(size) + 1)) - 2) : 16'h0a50 + 16'(size);
            len  = (variant == 0) ? 5'(int'(size) + 1) : 5'd12;
        end else if (kind == 2'd1 && run <= 2'd2 && size >= 4'd1 && size <= 4'd8) begin
            code = (variant == 0) ? 16'(32 + k) : 16'hc000 | 16'(k << 3) | 16'h5;
            len  = (variant == 0) ? 5'd6 : 5'd16;
        end else if (addr == 8'h80) begin
            code = (variant == 0) ? 16'h0 : 16'h2;
            len  = (variant == 0) ? 5'd2 : 5'd3;
        end
    endfunction

    task automatic load_table(input int variant);
        logic [15:0] code;
        logic [4:0]  len;
        for (int a = 0; a < 256; a++) begin
            @(negedge clk);
            table_entry(variant, 8'(a), code, len);
            i_tbl_we   = 1'b1;
            i_tbl_addr = 8'(a);
            i_tbl_code = code;
            i_tbl_len  = len;
            ref_code[a] = code;
            ref_len[a]  = len;
        end
        @(negedge clk);
        i_tbl_we = 1'b0;
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic int category(input int v);
        int m;
        int c;
        m = (v < 0) ? -v : v;
        c = 0;
        for (int b = 0; b < 16; b++) begin
            if ((m >> b) != 0) begin
                c = b + 1;
            end
        end
        return c;
    endfunction

    function automatic void put_bits(input logic [15:0] code, input int len);
        for (int i = len - 1; i >= 0; i--) begin
            bit_q.push_back(code[i]);
        end
    endfunction

    // negative values go out as the inverted magnitude
    function automatic void put_amp(input int v, input int cat);
        int a;
        a = (v < 0) ? ~(-v) : v;
        put_bits(16'(a & ((1 << cat) - 1)), cat);
    endfunction

    function automatic void model_block(input int comp,
                                        input logic [3:0][7:0] data);
        int         coef [4];
        int         diff;
        int         cat;
        int         last;
        int         run;
        logic [7:0] addr;
        logic [7:0] byte_val;
        bit_q.delete();
        exp_q.delete();
        for (int k = 0; k < 4; k++) begin
            coef[k] = int'($signed(data[k]));
        end
        diff           = coef[0] - ref_pred[comp];
        ref_pred[comp] = coef[0];
        cat            = category(diff);
        put_bits(ref_code[cat], int'(ref_len[cat]));
        if (cat != 0) begin
            put_amp(diff, cat);
        end
        last = 0;
        for (int k = 1; k < 4; k++) begin
            if (coef[k] != 0) begin
                last = k;
            end
        end
        run = 0;
        for (int k = 1; k <= last; k++) begin
            if (coef[k] == 0) begin
                run++;
            end else begin
                cat  = category(coef[k]);
                addr = 8'h40 + 8'(run * 16 + cat);
                put_bits(ref_code[addr], int'(ref_len[addr]));
                put_amp(coef[k], cat);
                run = 0;
            end
        end
        if (last < `HUFF_NUM_COEF - 1) begin
            put_bits(ref_code[8'h80], int'(ref_len[8'h80]));
        end
        // one-padding up to a byte
        while (bit_q.size() % 8 != 0) begin
            bit_q.push_back(1'b1);
        end
        for (int i = 0; i < bit_q.size(); i += 8) begin
            byte_val = 8'h00;
            for (int j = 0; j < 8; j++) begin
                byte_val = {byte_val[6:0], bit_q[i + j]};
            end
            exp_q.push_back(byte_val);
        end
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic add_row(input int comp, input int c0, input int c1, input int c2,
                           input int c3, input bit stall, input int variant);
        logic [3:0][7:0] d;
        d[0] = 8'(c0);
        d[1] = 8'(c1);
        d[2] = 8'(c2);
        d[3] = 8'(c3);
        row_comp.push_back(comp);
        row_data.push_back(d);
        row_stall.push_back(stall);
        row_variant.push_back(variant);
    endtask

    function automatic int rand_coef();
        int r;
        r = $random(seed);
        // roughly a quarter zeros
        if ((r & 3) == 0) begin
            return 0;
        end
        return (r >>> 8) % 128;
    endfunction

    task automatic build_rows();
        // comp, dc, ac1, ac2, ac3, stall, table
        add_row(0,   25,   0,    0,   0, 1'b0, 0);
        add_row(1,   -7,   3,    0,   0, 1'b0, 0);
        add_row(0,   25,   0,    0,   5, 1'b0, 0);
        add_row(0,   30,  -2,    0,   0, 1'b0, 0);
        add_row(2, -100,  -1, -128,   0, 1'b0, 0);
        add_row(0, -128, 127,    0, -64, 1'b0, 0);
        add_row(2,   12,   0,    0,  -3, 1'b0, 0);
        add_row(2,   12,   0,    9,   0, 1'b0, 0);
        add_row(1,    0,   1,    1,   1, 1'b0, 0);
        add_row(0,   77,   0,   -5,  33, 1'b1, 0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            add_row(int'($unsigned($random(seed)) % 3), rand_coef(), rand_coef(),
                    rand_coef(), rand_coef(), n % 2 == 1, 0);
        end
        // same kinds of blocks under the second table
        add_row(0,   25,   0,    0,   0, 1'b0, 1);
        add_row(1,   -7,   0,    6,   0, 1'b1, 1);
        add_row(2,   55,  -1,    0, 100, 1'b0, 1);
        for (int n = 0; n < 4; n++) begin
            add_row(int'($unsigned($random(seed)) % 3), rand_coef(), rand_coef(),
                    rand_coef(), rand_coef(), 1'b1, 1);
        end
    endtask

    // random stall stretches of 1 to 6 cycles
    task automatic drive_stall();
        if (stall_left > 0) begin
            i_wait = 1'b1;
            stall_left--;
        end else begin
            i_wait = 1'b0;
            if (($random(seed) & 3) == 0) begin
                stall_left = 1 + ($unsigned($random(seed)) % 6);
            end
        end
    endtask

    task automatic run_block(input int idx);
        int got;
        int cycles;
        bit done;
        bit ok;
        model_block(row_comp[idx], row_data[idx]);
        got        = 0;
        cycles     = 0;
        done       = 1'b0;
        ok         = 1'b1;
        stall_left = 0;
        @(negedge clk);
        i_comp  = 2'(row_comp[idx]);
        i_data  = row_data[idx];
        i_wait  = 1'b0;
        i_start = 1'b1;
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge clk);
            i_start = 1'b0;
            if (row_stall[idx]) begin
                drive_stall();
            end else begin
                i_wait = 1'b0;
            end
            #(CLK_PERIOD / 4);
            cycles++;
            if (o_valid) begin
                if (i_wait) begin
                    $display("test %0d: o_valid went high while i_wait was high", idx);
                    ok = 1'b0;
                end
                if (got < exp_q.size() && o_data !== exp_q[got]) begin
                    $display("Mismatch o_data byte %0d: expected %h got %h",
                             got, exp_q[got], o_data);
                    ok = 1'b0;
                end
                got++;
            end
            if (o_done) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("test %0d: timed out waiting for o_done", idx);
            ok      = 1'b0;
            aborted = 1'b1;
        end else if (got != exp_q.size()) begin
            $display("Mismatch byte count: expected %h got %h", exp_q.size(), got);
            ok = 1'b0;
        end
        $display("test %0d: comp %0d, %0d bytes, %s", idx, row_comp[idx], got,
                 ok ? "ok" : "error");
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        seed       = 32'h0b75db52;
        n_rst      = 1'b0;
        i_tbl_we   = 1'b0;
        i_tbl_addr = '0;
        i_tbl_code = '0;
        i_tbl_len  = '0;
        i_start    = 1'b0;
        i_wait     = 1'b0;
        i_comp     = '0;
        i_data     = '0;
        pass_count = 0;
        fail_count = 0;
        aborted    = 1'b0;
        stall_left = 0;
        for (int c = 0; c < 3; c++) begin
            ref_pred[c] = 0;
        end
        build_rows();
        repeat (RST_CYCLES) @(negedge clk);
        n_rst = 1'b1;
        load_table(0);
        loaded = 0;
        for (int r = 0; r < row_comp.size() && !aborted; r++) begin
            if (row_variant[r] != loaded) begin
                load_table(row_variant[r]);
                loaded = row_variant[r];
            end
            run_block(r);
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hdl/huff_pkg.sv
hdl/huff_wr_if.sv
hdl/huff_code_table.sv
hdl/coef_coder.sv
hdl/run_counter.sv
hdl/encode_fsm.sv
hdl/bit_packer.sv
hdl/huff_enc_top.sv
test/tb_huff_enc.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_huff_enc -f filelist.f -o tb_huff_enc

./obj_dir/tb_huff_enc > sim.log
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
